/* rtl/sram_tester_pkg.sv */
`default_nettype none

package sram_tester_pkg;

  // pattern index width and how many patterns make one round
  localparam int PATTERN_BITS = 3;
  localparam int NUM_PATTERNS = 5;

  // command kind carried through the FIFO
  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } sram_op_e;

endpackage

`default_nettype wire

/* rtl/cmd_push_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface cmd_push_if #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) ();

  import sram_tester_pkg::*;

  logic                    push;
  logic                    full;
  sram_op_e                op;
  logic                    last;
  logic [PATTERN_BITS-1:0] pattern;
  logic [ADDR_BITS-1:0]    addr;
  // write data, or expected data for a read
  logic [DATA_BITS-1:0]    data;

  modport producer (
    output push, op, last, pattern, addr, data,
    input  full
  );

  modport fifo (
    input  push, op, last, pattern, addr, data,
    output full
  );

endinterface

`default_nettype wire

/* rtl/cmd_pop_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface cmd_pop_if #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) ();

  import sram_tester_pkg::*;

  logic                    pop;
  logic                    empty;
  // head entry, valid while empty is low
  sram_op_e                op;
  logic                    last;
  logic [PATTERN_BITS-1:0] pattern;
  logic [ADDR_BITS-1:0]    addr;
  logic [DATA_BITS-1:0]    data;

  modport fifo (
    output empty, op, last, pattern, addr, data,
    input  pop
  );

  modport port (
    input  empty, op, last, pattern, addr, data,
    output pop
  );

endinterface

`default_nettype wire

/* rtl/pattern_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module pattern_sequencer #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input logic          CLK,
  input logic          rst_n,
  cmd_push_if.producer cmd
);

  import sram_tester_pkg::*;

  logic [PATTERN_BITS-1:0] pattern;
  sram_op_e                phase;
  logic [ADDR_BITS-1:0]    addr;
  logic                    top_addr;
  logic                    last_pattern;

  // data word for pattern p at address a
  function automatic logic [DATA_BITS-1:0] pattern_word(
    input logic [PATTERN_BITS-1:0] p,
    input logic [ADDR_BITS-1:0]    a
  );
    logic [DATA_BITS-1:0] w;
    w = DATA_BITS'(a);
    case (p)
      PATTERN_BITS'(0): w = DATA_BITS'(a);
      PATTERN_BITS'(1): w = ~DATA_BITS'(a);
      PATTERN_BITS'(2): w = '0;
      PATTERN_BITS'(3): w = '1;
      default: begin
        // 0101 on even addresses, 1010 on odd
        for (int i = 0; i < DATA_BITS; i++) begin
          w[i] = ~(i[0] ^ a[0]);
        end
      end
    endcase
    return w;
  endfunction

  assign top_addr     = &addr;
  assign last_pattern = (pattern == PATTERN_BITS'(NUM_PATTERNS - 1));

  // one command per cycle unless the FIFO is full
  assign cmd.push    = ~cmd.full;
  assign cmd.op      = phase;
  assign cmd.pattern = pattern;
  assign cmd.addr    = addr;
  assign cmd.data    = pattern_word(pattern, addr);
  assign cmd.last    = (phase == OP_READ) && top_addr && last_pattern;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pattern <= '0;
      phase   <= OP_WRITE;
      addr    <= '0;
    end else if (cmd.push) begin
      addr <= addr + 1'b1;
      if (top_addr) begin
        if (phase == OP_WRITE) begin
          phase <= OP_READ;
        end else begin
          phase <= OP_WRITE;
          // wrap back to pattern 0 after the final read pass
          pattern <= last_pattern ? '0 : pattern + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/cmd_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module cmd_fifo #(
  parameter int ADDR_BITS  = 20,
  parameter int DATA_BITS  = 16,
  parameter int FIFO_DEPTH = 4
) (
  input logic      CLK,
  input logic      rst_n,
  cmd_push_if.fifo wr,
  cmd_pop_if.fifo  rd
);

  import sram_tester_pkg::*;

  localparam int PTR_BITS   = $clog2(FIFO_DEPTH);
  localparam int CNT_BITS   = PTR_BITS + 1;
  localparam int ENTRY_BITS = 2 + PATTERN_BITS + ADDR_BITS + DATA_BITS;

  // entry layout, msb first: op, last, pattern, addr, data
  logic [ENTRY_BITS-1:0] mem [FIFO_DEPTH];
  logic [ENTRY_BITS-1:0] head;
  logic [PTR_BITS-1:0]   wr_ptr;
  logic [PTR_BITS-1:0]   rd_ptr;
  logic [CNT_BITS-1:0]   count;

  assign wr.full  = (count == CNT_BITS'(FIFO_DEPTH));
  assign rd.empty = (count == '0);

  assign head       = mem[rd_ptr];
  assign rd.data    = head[DATA_BITS-1:0];
  assign rd.addr    = head[DATA_BITS +: ADDR_BITS];
  assign rd.pattern = head[DATA_BITS + ADDR_BITS +: PATTERN_BITS];
  assign rd.last    = head[ENTRY_BITS-2];
  assign rd.op      = sram_op_e'(head[ENTRY_BITS-1]);

  always_ff @(posedge CLK) begin
    if (wr.push) begin
      mem[wr_ptr] <= {wr.op, wr.last, wr.pattern, wr.addr, wr.data};
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap on their own, depth is a power of two
      if (wr.push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd.pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr.push, rd.pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/sram_port.sv */
`timescale 1ns/1ns
`default_nettype none

module sram_port #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  logic                 CLK,
  input  logic                 rst_n,
  cmd_pop_if.port              cmd,
  input  logic [DATA_BITS-1:0] sram_dq_in,

  output logic [ADDR_BITS-1:0] sram_addr,
  output logic [DATA_BITS-1:0] sram_dq_out,
  output logic                 sram_dq_oe,
  output logic                 sram_ce_n,
  output logic                 sram_we_n,
  output logic                 sram_oe_n,

  output logic                 test_done,
  output logic                 test_pass,
  output logic [7:0]           last_expected,
  output logic [7:0]           last_read
);

  import sram_tester_pkg::*;

  // low in the setup cycle (or idle), high in the strobe cycle
  logic strobe;
  logic active;
  logic is_write;
  logic is_read;
  logic miss;
  logic round_end;
  logic round_fail;

  // the head stays put until the pop in the strobe cycle
  assign active   = ~cmd.empty;
  assign is_write = active && (cmd.op == OP_WRITE);
  assign is_read  = active && (cmd.op == OP_READ);

  assign sram_addr   = active ? cmd.addr : '0;
  assign sram_dq_out = is_write ? cmd.data : '0;
  assign sram_dq_oe  = is_write;
  assign sram_ce_n   = ~active;
  // write enable only in the second cycle, addr and data settle first
  assign sram_we_n   = ~(is_write && strobe);
  assign sram_oe_n   = ~is_read;

  assign cmd.pop = strobe;

  // read data is taken at the end of the strobe cycle
  assign miss      = strobe && is_read && (sram_dq_in != cmd.data);
  assign round_end = strobe && cmd.last;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      strobe <= 1'b0;
    end else begin
      strobe <= ~strobe && active;
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      round_fail <= 1'b0;
      test_done  <= 1'b0;
      test_pass  <= 1'b0;
    end else begin
      test_done <= round_end;
      if (round_end) begin
        // result covers this round only
        test_pass  <= ~(round_fail || miss);
        round_fail <= 1'b0;
      end else if (miss) begin
        round_fail <= 1'b1;
      end
    end
  end

  // low bytes of the latest mismatch, kept across rounds
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      last_expected <= '0;
      last_read     <= '0;
    end else if (miss) begin
      last_expected <= cmd.data[7:0];
      last_read     <= sram_dq_in[7:0];
    end
  end

endmodule

`default_nettype wire

/* rtl/led_mapper.sv */
`timescale 1ns/1ns
`default_nettype none

module led_mapper #(
  parameter int ADDR_BITS = 20
) (
  input  logic                                  CLK,
  input  logic                                  rst_n,
  input  logic [ADDR_BITS-1:0]                  addr,
  input  logic [sram_tester_pkg::PATTERN_BITS-1:0] pattern,
  output logic [7:0]                            dbg_e,
  output logic [7:0]                            dbg_f,
  output logic [7:0]                            dbg_h
);

  import sram_tester_pkg::*;

  logic [ADDR_BITS-1:0]    addr_q;
  logic [ADDR_BITS-1:0]    addr_rev;
  logic [PATTERN_BITS-1:0] pattern_rev;

  // one stage on the address, lags the pins by a cycle
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else begin
      addr_q <= addr;
    end
  end

  always_comb begin
    for (int i = 0; i < ADDR_BITS; i++) begin
      addr_rev[i] = addr_q[ADDR_BITS-1-i];
    end
    for (int j = 0; j < PATTERN_BITS; j++) begin
      pattern_rev[j] = pattern[PATTERN_BITS-1-j];
    end
  end

  assign dbg_e[2:0] = pattern_rev;
  assign dbg_e[3]   = 1'b0;

  generate
    if (ADDR_BITS >= 16) begin : g_wide
      logic [ADDR_BITS+7:0] rev_ext;
      // zero pad so the top byte always exists
      assign rev_ext    = {8'b0, addr_rev};
      assign dbg_e[7:4] = addr_rev[3:0];
      assign dbg_f      = addr_rev[11:4];
      assign dbg_h      = rev_ext[19:12];
    end else begin : g_narrow
      assign dbg_e[7:4] = 4'b0;
      assign dbg_f      = 8'(addr_rev[ADDR_BITS-1:ADDR_BITS/2]);
      assign dbg_h      = 8'(addr_rev[ADDR_BITS/2-1:0]);
    end
  endgenerate

endmodule

`default_nettype wire

/* rtl/sram_tester_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sram_tester_top #(
  parameter int ADDR_BITS  = 20,
  parameter int DATA_BITS  = 16,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                 CLK,
  input  logic                 rst_n,
  output logic                 led_done,
  output logic                 led_pass,

  output logic [ADDR_BITS-1:0] sram_addr,
  output logic [DATA_BITS-1:0] sram_dq_out,
  input  logic [DATA_BITS-1:0] sram_dq_in,
  output logic                 sram_dq_oe,
  output logic                 sram_ce_n,
  output logic                 sram_we_n,
  output logic                 sram_oe_n,

  output logic [7:0]           dbg_e,
  output logic [7:0]           dbg_f,
  output logic [7:0]           dbg_h,
  output logic [7:0]           dbg_i,
  output logic [7:0]           dbg_j
);

  cmd_push_if #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) push_bus ();

  cmd_pop_if #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) pop_bus ();

  pattern_sequencer #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_sequencer (
    .CLK  (CLK),
    .rst_n(rst_n),
    .cmd  (push_bus)
  );

  cmd_fifo #(
    .ADDR_BITS (ADDR_BITS),
    .DATA_BITS (DATA_BITS),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .CLK  (CLK),
    .rst_n(rst_n),
    .wr   (push_bus),
    .rd   (pop_bus)
  );

  // done and pass go straight to the leds, mismatch bytes to dbg_i/dbg_j
  sram_port #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_port (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .cmd          (pop_bus),
    .sram_dq_in   (sram_dq_in),
    .sram_addr    (sram_addr),
    .sram_dq_out  (sram_dq_out),
    .sram_dq_oe   (sram_dq_oe),
    .sram_ce_n    (sram_ce_n),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n),
    .test_done    (led_done),
    .test_pass    (led_pass),
    .last_expected(dbg_i),
    .last_read    (dbg_j)
  );

  led_mapper #(
    .ADDR_BITS(ADDR_BITS)
  ) u_leds (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .addr   (sram_addr),
    .pattern(pop_bus.pattern),
    .dbg_e  (dbg_e),
    .dbg_f  (dbg_f),
    .dbg_h  (dbg_h)
  );

endmodule

`default_nettype wire

/* dv/sram_tester_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module sram_port_properties (
  input logic CLK,
  input logic rst_n,
  input logic we_n,
  input logic oe_n,
  input logic dq_oe,
  input logic pop,
  input logic empty
);

  // read and write strobes never overlap, the setup cycle included
  we_oe_exclusive: assert property (@(posedge CLK) disable iff (!rst_n)
    !we_n |-> oe_n && $past(oe_n))
    else $error("oe_n is low around a write strobe");

  // data bus is driven in the setup and the strobe cycle of a write
  write_drives_bus: assert property (@(posedge CLK) disable iff (!rst_n)
    !we_n |-> dq_oe && $past(dq_oe))
    else $error("dq_oe is not high through the whole write");

  no_pop_when_empty: assert property (@(posedge CLK) disable iff (!rst_n)
    empty |-> !pop)
    else $error("pop raised while the FIFO is empty");

endmodule

bind sram_port sram_port_properties u_properties (
  .CLK  (CLK),
  .rst_n(rst_n),
  .we_n (sram_we_n),
  .oe_n (sram_oe_n),
  .dq_oe(sram_dq_oe),
  .pop  (cmd.pop),
  .empty(cmd.empty)
);

`default_nettype wire

/* dv/tb_sram_tester.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_sram_tester;

  import sram_tester_pkg::*;

  localparam int ADDR_BITS    = 4;
  localparam int DATA_BITS    = 16;
  localparam int FIFO_DEPTH   = 4;
  localparam int WORDS        = 1 << ADDR_BITS;
  localparam int NUM_TESTS    = 5;
  localparam int ROUND_CYCLES = 400;

  logic                 CLK = 1'b0;
  logic                 rst_n;
  logic                 led_done;
  logic                 led_pass;
  logic [ADDR_BITS-1:0] sram_addr;
  logic [DATA_BITS-1:0] sram_dq_out;
  logic [DATA_BITS-1:0] sram_dq_in;
  logic                 sram_dq_oe;
  logic                 sram_ce_n;
  logic                 sram_we_n;
  logic                 sram_oe_n;
  logic [7:0]           dbg_e;
  logic [7:0]           dbg_f;
  logic [7:0]           dbg_h;
  logic [7:0]           dbg_i;
  logic [7:0]           dbg_j;

  // sram model and the fault of the running test
  logic [DATA_BITS-1:0] mem [WORDS];
  logic [ADDR_BITS-1:0] fault_addr;
  logic [DATA_BITS-1:0] fault_mask;
  logic                 mem_filled = 1'b0;

  // test table
  string                t_name  [NUM_TESTS];
  logic [ADDR_BITS-1:0] t_addr  [NUM_TESTS];
  logic [DATA_BITS-1:0] t_mask  [NUM_TESTS];
  logic                 t_pass  [NUM_TESTS];
  logic [7:0]           t_exp_e [NUM_TESTS];
  logic [7:0]           t_exp_r [NUM_TESTS];

  string                cur_name;
  int                   error_count = 0;
  int                   tests_passed = 0;
  int                   tests_failed = 0;
  int                   write_count = 0;
  logic [ADDR_BITS-1:0] prev_addr = '0;

  always #2 CLK = ~CLK;

  sram_tester_top #(
    .ADDR_BITS (ADDR_BITS),
    .DATA_BITS (DATA_BITS),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) DUT (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .led_done   (led_done),
    .led_pass   (led_pass),
    .sram_addr  (sram_addr),
    .sram_dq_out(sram_dq_out),
    .sram_dq_in (sram_dq_in),
    .sram_dq_oe (sram_dq_oe),
    .sram_ce_n  (sram_ce_n),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .dbg_e      (dbg_e),
    .dbg_f      (dbg_f),
    .dbg_h      (dbg_h),
    .dbg_i      (dbg_i),
    .dbg_j      (dbg_j)
  );

  // reference data for pattern p at address a
  function automatic logic [DATA_BITS-1:0] expected_word(input int p,
                                                         input logic [ADDR_BITS-1:0] a);
    logic [DATA_BITS-1:0] w;
    case (p)
      0: w = DATA_BITS'(a);
      1: w = ~DATA_BITS'(a);
      2: w = '0;
      3: w = '1;
      default: w = a[0] ? {(DATA_BITS/2){2'b10}} : {(DATA_BITS/2){2'b01}};
    endcase
    return w;
  endfunction

  function automatic logic [ADDR_BITS-1:0] reverse_addr(input logic [ADDR_BITS-1:0] a);
    logic [ADDR_BITS-1:0] r;
    for (int i = 0; i < ADDR_BITS; i++) begin
      r[i] = a[ADDR_BITS-1-i];
    end
    return r;
  endfunction

  function automatic logic [PATTERN_BITS-1:0] reverse_pattern(input int p);
    logic [PATTERN_BITS-1:0] v;
    logic [PATTERN_BITS-1:0] r;
    v = PATTERN_BITS'(p);
    for (int i = 0; i < PATTERN_BITS; i++) begin
      r[i] = v[PATTERN_BITS-1-i];
    end
    return r;
  endfunction

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      error_count++;
      $display("MISMATCH %s %s: expected %b, actual %b", cur_name, what, exp, act);
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      error_count++;
      $display("MISMATCH %s %s: expected %h, actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic check_word(input string what, input logic [DATA_BITS-1:0] exp,
                            input logic [DATA_BITS-1:0] act);
    if (act !== exp) begin
      error_count++;
      $display("MISMATCH %s %s: expected %h, actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic build_table();
    logic [7:0]           held_e;
    logic [7:0]           held_r;
    logic [DATA_BITS-1:0] word;
    held_e = '0;
    held_r = '0;
    t_name[0] = "no_fault";
    t_addr[0] = ADDR_BITS'(0);
    t_mask[0] = 16'h0000;
    t_name[1] = "bit0_at_3";
    t_addr[1] = ADDR_BITS'(3);
    t_mask[1] = 16'h0001;
    t_name[2] = "bit15_at_9";
    t_addr[2] = ADDR_BITS'(9);
    t_mask[2] = 16'h8000;
    t_name[3] = "low_byte_at_15";
    t_addr[3] = ADDR_BITS'(15);
    t_mask[3] = 16'h00ff;
    t_name[4] = "no_fault_again";
    t_addr[4] = ADDR_BITS'(0);
    t_mask[4] = 16'h0000;
    for (int t = 0; t < NUM_TESTS; t++) begin
      t_pass[t] = (t_mask[t] == '0);
      if (!t_pass[t]) begin
        // pattern 4 is the last read of the faulty word in a round
        word   = expected_word(NUM_PATTERNS - 1, t_addr[t]);
        held_e = word[7:0];
        held_r = word[7:0] ^ t_mask[t][7:0];
      end
      // debug bytes keep the previous mismatch on a clean round
      t_exp_e[t] = held_e;
      t_exp_r[t] = held_r;
    end
  endtask

  task automatic wait_done();
    do begin
      @(negedge CLK);
    end while (led_done !== 1'b1);
  endtask

  // asynchronous read path with the fault applied
  always_comb begin
    sram_dq_in = '0;
    if (sram_ce_n == 1'b0 && sram_oe_n == 1'b0) begin
      sram_dq_in = mem[sram_addr];
      if (sram_addr == fault_addr) begin
        sram_dq_in = sram_dq_in ^ fault_mask;
      end
    end
  end

  // write port, write data monitor and debug monitor
  always @(negedge CLK) begin
    int pat;
    if (!rst_n) begin
      if (!mem_filled) begin
        for (int i = 0; i < WORDS; i++) begin
          mem[i] = DATA_BITS'($urandom);
        end
        mem_filled = 1'b1;
      end
      write_count = 0;
    end else begin
      if (sram_ce_n == 1'b0) begin
        // reads of a pass come after all of its writes
        if (sram_oe_n == 1'b0) begin
          pat = ((write_count - 1) / WORDS) % NUM_PATTERNS;
        end else begin
          pat = (write_count / WORDS) % NUM_PATTERNS;
        end
        check_byte("dbg_e", 8'(reverse_pattern(pat)), dbg_e);
      end
      if (sram_ce_n == 1'b0 && sram_we_n == 1'b0) begin
        check_bit("dq_oe", 1'b1, sram_dq_oe);
        check_word("write data",
                   expected_word((write_count / WORDS) % NUM_PATTERNS, sram_addr),
                   sram_dq_out);
        mem[sram_addr] = sram_dq_out;
        write_count++;
      end
      check_byte("dbg_f", 8'(reverse_addr(prev_addr) >> (ADDR_BITS/2)), dbg_f);
      check_byte("dbg_h", 8'(reverse_addr(prev_addr) & ADDR_BITS'((1 << (ADDR_BITS/2)) - 1)),
                 dbg_h);
    end
    prev_addr = sram_addr;
  end

  initial begin
    int errors_before;
    rst_n      = 1'b0;
    fault_addr = '0;
    fault_mask = '0;
    void'($urandom(84802));
    build_table();
    cur_name = "reset";
    repeat (10) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    #1;
    // no command has reached the pins yet
    check_bit("ce_n", 1'b1, sram_ce_n);
    check_bit("we_n", 1'b1, sram_we_n);
    check_bit("oe_n", 1'b1, sram_oe_n);
    check_bit("dq_oe", 1'b0, sram_dq_oe);
    check_bit("led_done", 1'b0, led_done);
    check_bit("led_pass", 1'b0, led_pass);
    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_name      = t_name[t];
      errors_before = error_count;
      fault_addr    = t_addr[t];
      fault_mask    = t_mask[t];
      wait_done();
      check_bit("led_pass", t_pass[t], led_pass);
      check_byte("dbg_i", t_exp_e[t], dbg_i);
      check_byte("dbg_j", t_exp_r[t], dbg_j);
      if (error_count == errors_before) begin
        tests_passed++;
        $display("test %s: ok", cur_name);
      end else begin
        tests_failed++;
        $display("test %s: FAILED with %0d errors", cur_name, error_count - errors_before);
      end
      @(posedge CLK);
      #1;
    end
    $display("tests %0d, ok %0d, failed %0d, check errors %0d",
             NUM_TESTS, tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // a round takes a little over 320 cycles
  initial begin
    repeat ((NUM_TESTS + 2) * ROUND_CYCLES) @(posedge CLK);
    $display("timeout waiting for round done");
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
rtl/sram_tester_pkg.sv
rtl/cmd_push_if.sv
rtl/cmd_pop_if.sv
rtl/pattern_sequencer.sv
rtl/cmd_fifo.sv
rtl/sram_port.sv
rtl/led_mapper.sv
rtl/sram_tester_top.sv
dv/sram_tester_properties.sv
dv/tb_sram_tester.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the SRAM tester testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_sram_tester \
  --Mdir obj_dir -o tb_sram_tester \
  -f all.f

# the simulation may stop early on an assertion, the log decides
./obj_dir/tb_sram_tester > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
  echo "simulation PASS"
  exit 0
else
  echo "simulation FAIL"
  exit 1
fi
